//--- compile.f
pcie_rx_pkg.sv
req_fifo.sv
tlp_rx_parser.sv
req_dispatcher.sv
pcie_rx_ep.sv
pcie_rx_ep_properties.sv
pcie_rx_ep_tb.sv

//--- pcie_rx_ep.sv
/*
 * PCIe receive endpoint top level.
 * Parser feeding a read FIFO and a write FIFO, drained by the dispatcher.
 */

module pcie_rx_ep import pcie_rx_pkg::*; #(
    parameter int P_FIFO_DEPTH = 4
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  axis_rx_t   rx,
    output logic       rx_tready,
    output logic       req_compl,
    output compl_req_t compl,
    input  logic       compl_done,
    output logic       wr_en,
    output mem_wr_t    wr,
    input  logic       wr_done
);

    logic       rd_room;
    logic       rd_push;
    compl_req_t rd_req;
    logic       rd_pop;
    compl_req_t rd_head;
    logic       rd_not_empty;

    logic       wr_room;
    logic       wr_push;
    mem_wr_t    wr_req;
    logic       wr_pop;
    mem_wr_t    wr_head;
    logic       wr_not_empty;

    tlp_rx_parser tlp_rx_parser_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .rx        (rx),
        .rx_tready (rx_tready),
        .rd_room   (rd_room),
        .wr_room   (wr_room),
        .rd_push   (rd_push),
        .rd_req    (rd_req),
        .wr_push   (wr_push),
        .wr_req    (wr_req)
    );

    // Completion requests
    req_fifo #(
        .P_DEPTH   (P_FIFO_DEPTH),
        .payload_t (compl_req_t)
    ) rd_fifo_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .push      (rd_push),
        .push_data (rd_req),
        .room      (rd_room),
        .pop       (rd_pop),
        .head      (rd_head),
        .not_empty (rd_not_empty)
    );

    // Local writes
    req_fifo #(
        .P_DEPTH   (P_FIFO_DEPTH),
        .payload_t (mem_wr_t)
    ) wr_fifo_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .push      (wr_push),
        .push_data (wr_req),
        .room      (wr_room),
        .pop       (wr_pop),
        .head      (wr_head),
        .not_empty (wr_not_empty)
    );

    req_dispatcher req_dispatcher_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .rd_head      (rd_head),
        .rd_not_empty (rd_not_empty),
        .rd_pop       (rd_pop),
        .wr_head      (wr_head),
        .wr_not_empty (wr_not_empty),
        .wr_pop       (wr_pop),
        .req_compl    (req_compl),
        .compl        (compl),
        .compl_done   (compl_done),
        .wr_en        (wr_en),
        .wr           (wr),
        .wr_done      (wr_done)
    );

endmodule

//--- pcie_rx_ep_properties.sv
/*
 * Bound assertions for the PCIe receive endpoint.
 * Reset levels, completion and write fields, discarded TLPs,
 * strobe width and ordering, and the idle request latency.
 */

module pcie_rx_ep_properties import pcie_rx_pkg::*; (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       rx_tready,
    input logic       req_compl,
    input compl_req_t compl,
    input logic       compl_done,
    input logic       wr_en,
    input mem_wr_t    wr,
    input logic       wr_done,
    input logic       rd_push,
    input logic       wr_push,
    input logic       rd_not_empty,
    input logic       wr_not_empty
);

    timeunit 1ns;
    timeprecision 1ps;

    // Requester context sent with every read: ID 0100, byte enables 0F, one dword
    localparam logic [48:0] EXP_CTX = {3'b0, 1'b0, 1'b0, 2'b0, 10'd1, 16'h0100, 8'h0F};

    int          fail_count = 0;
    logic [7:0]  exp_tag;
    logic [31:0] exp_addr;
    logic [48:0] compl_ctx;
    // Strobe issued, done not yet back
    logic        busy;
    logic        quiet;

    assign quiet = !busy && !req_compl && !wr_en && !rd_not_empty && !wr_not_empty;

    assign compl_ctx = {compl.tc, compl.td, compl.ep, compl.attr, compl.len,
                        compl.rid, compl.be};

    task automatic count_failure(input string msg);
        $error("%s", msg);
        fail_count++;
    endtask

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            busy     <= 1'b0;
            exp_tag  <= 8'h00;
            exp_addr <= 32'h2000;
        end else begin
            if (req_compl || wr_en) begin
                busy <= 1'b1;
            end else if (compl_done || wr_done) begin
                busy <= 1'b0;
            end
            if (req_compl) begin
                exp_tag <= exp_tag + 8'h01;
            end
            if (wr_en) begin
                exp_addr <= exp_addr + 32'd4;
            end
        end
    end

    a_reset_low: assert property (@(posedge i_clk)
        i_rst_n ##1 i_rst_n |-> !rx_tready && !req_compl && !wr_en && !rd_push && !wr_push)
        else count_failure("outputs or push strobes not low during reset");

    a_ready_after_reset: assert property (@(posedge i_clk) $fell(i_rst_n) |=> rx_tready)
        else count_failure("rx_tready not high one cycle after reset release");

    a_compl_tag: assert property (@(posedge i_clk) disable iff (i_rst_n)
        req_compl |-> compl.tag == exp_tag)
        else count_failure($sformatf("error at %0t ns: compl.tag is %0h, expected %0h",
            $time, $sampled(compl.tag), $sampled(exp_tag)));

    a_compl_addr: assert property (@(posedge i_clk) disable iff (i_rst_n)
        req_compl |-> compl.addr == 32'h1000 + {22'h0, exp_tag, 2'b00})
        else count_failure($sformatf("error at %0t ns: compl.addr is %0h, expected %0h",
            $time, $sampled(compl.addr), 32'h1000 + {22'h0, $sampled(exp_tag), 2'b00}));

    a_compl_ctx: assert property (@(posedge i_clk) disable iff (i_rst_n)
        req_compl |-> compl_ctx == EXP_CTX)
        else count_failure($sformatf("error at %0t ns: compl context is %0h, expected %0h",
            $time, $sampled(compl_ctx), EXP_CTX));

    a_wr_addr: assert property (@(posedge i_clk) disable iff (i_rst_n)
        wr_en |-> wr.addr == exp_addr)
        else count_failure($sformatf("error at %0t ns: wr.addr is %0h, expected %0h",
            $time, $sampled(wr.addr), $sampled(exp_addr)));

    a_wr_data: assert property (@(posedge i_clk) disable iff (i_rst_n)
        wr_en |-> wr.data == ~exp_addr)
        else count_failure($sformatf("error at %0t ns: wr.data is %0h, expected %0h",
            $time, $sampled(wr.data), ~$sampled(exp_addr)));

    a_wr_be: assert property (@(posedge i_clk) disable iff (i_rst_n)
        wr_en |-> wr.be == 8'h0F)
        else count_failure($sformatf("error at %0t ns: wr.be is %0h, expected %0h",
            $time, $sampled(wr.be), 8'h0F));

    // Discarded TLPs carry tag FF and address DEAD0000
    a_no_discard: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (req_compl |-> compl.tag != 8'hFF && compl.addr != 32'hDEAD_0000) and
        (wr_en |-> wr.addr != 32'hDEAD_0000))
        else count_failure("a discarded TLP reached the local side");

    a_strobe_width: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (req_compl |=> !req_compl) and (wr_en |=> !wr_en))
        else count_failure("strobe longer than one cycle");

    a_no_overlap: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (req_compl || wr_en) |-> !busy)
        else count_failure("new strobe before done of the previous one");

    a_idle_latency: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (rd_push || wr_push) && quiet |-> ##2 (req_compl || wr_en))
        else count_failure("idle request strobe not 3 cycles after its last beat");

endmodule

bind pcie_rx_ep pcie_rx_ep_properties props_i (.*);

//--- pcie_rx_ep_tb.sv
/*
 * Testbench for the PCIe receive endpoint.
 * One-dword reads and writes in both header alignments, discarded TLPs,
 * random valid gaps, a done responder, timeouts and final request counts.
 */

module pcie_rx_ep_tb import pcie_rx_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 400;

    logic        i_clk = 1'b0;
    logic        i_rst_n;
    axis_rx_t    rx;
    logic        rx_tready;
    logic        req_compl;
    compl_req_t  compl;
    logic        compl_done = 1'b0;
    logic        wr_en;
    mem_wr_t     wr;
    logic        wr_done = 1'b0;

    int          stim_seed = 92663;
    int          done_seed = 92663;
    logic [7:0]  rd_tag = 8'h00;
    logic [31:0] wr_addr = 32'h2000;
    int          n_rd_sent = 0;
    int          n_wr_sent = 0;
    int          n_rd_seen = 0;
    int          n_wr_seen = 0;
    bit          gaps_on = 1'b0;
    bit          slow_done = 1'b0;
    bit          tready_fell = 1'b0;

    always #4 i_clk = ~i_clk;

    pcie_rx_ep #(.P_FIFO_DEPTH(4)) pcie_rx_ep_i (.*);

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // Header dwords 0 and 1, requester ID 0100
    function automatic logic [63:0] tlp_header(input logic [6:0] fmt_type,
                                               input logic [9:0] len, input logic [7:0] tag);
        return {16'h0100, tag, 8'h0F, 1'b0, fmt_type, 14'h0, len};
    endfunction

    task automatic drive_beat(input logic [127:0] data, input logic sof,
                              input logic mid, input logic last);
        logic [TUSER_WIDTH-1:0] tuser;
        int                     wait_cycles;
        tuser                  = '0;
        tuser[SOF_PRESENT_BIT] = sof;
        tuser[SOF_MID_BIT]     = mid;
        if (gaps_on && ($random(stim_seed) & 3) == 0) begin
            rx.tvalid <= 1'b0;
            @(posedge i_clk);
        end
        rx <= '{tdata: data, tuser: tuser, tlast: last, tvalid: 1'b1};
        wait_cycles = 0;
        @(posedge i_clk);
        while (!rx_tready) begin
            wait_cycles++;
            if (wait_cycles > TIMEOUT) begin
                report_failure("timeout: receive beat was never accepted");
            end
            @(posedge i_clk);
        end
    endtask

    task automatic send_rd(input bit mid);
        logic [63:0] hdr;
        logic [31:0] addr;
        hdr  = tlp_header(MEM_RD32_FMT_TYPE, 10'd1, rd_tag);
        addr = 32'h1000 + {22'h0, rd_tag, 2'b00};
        if (mid) begin
            drive_beat({hdr, 64'h0}, 1'b1, 1'b1, 1'b0);
            drive_beat({96'h0, addr}, 1'b0, 1'b0, 1'b1);
        end else begin
            drive_beat({32'h0, addr, hdr}, 1'b1, 1'b0, 1'b1);
        end
        rd_tag++;
        n_rd_sent++;
    endtask

    task automatic send_wr(input bit mid);
        logic [63:0] hdr;
        hdr = tlp_header(MEM_WR32_FMT_TYPE, 10'd1, 8'h00);
        if (mid) begin
            drive_beat({hdr, 64'h0}, 1'b1, 1'b1, 1'b0);
            drive_beat({64'h0, ~wr_addr, wr_addr}, 1'b0, 1'b0, 1'b1);
        end else begin
            drive_beat({~wr_addr, wr_addr, hdr}, 1'b1, 1'b0, 1'b1);
        end
        wr_addr += 32'd4;
        n_wr_sent++;
    endtask

    // Two-dword TLPs, dropped by the parser
    task automatic send_discard(input bit mid);
        logic [63:0] hdr;
        if (mid) begin
            hdr = tlp_header(MEM_WR32_FMT_TYPE, 10'd2, 8'hFF);
            drive_beat({hdr, 64'h0}, 1'b1, 1'b1, 1'b0);
            drive_beat({96'h0, 32'hDEAD_0000}, 1'b0, 1'b0, 1'b1);
        end else begin
            hdr = tlp_header(MEM_RD32_FMT_TYPE, 10'd2, 8'hFF);
            drive_beat({32'h0, 32'hDEAD_0000, hdr}, 1'b1, 1'b0, 1'b1);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        rx.tvalid <= 1'b0;
        while (n_rd_seen < n_rd_sent || n_wr_seen < n_wr_sent) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("timeout: queued requests never reached the local side");
            end
            @(posedge i_clk);
        end
        // Gap so the last done returns before the next phase
        repeat (8) @(posedge i_clk);
    endtask

    // Done responder, one pulse per strobe
    always begin
        int delay;
        bit is_rd;
        @(posedge i_clk);
        if (req_compl || wr_en) begin
            is_rd = req_compl;
            delay = slow_done ? 6 : 1 + ($unsigned($random(done_seed)) % 6);
            repeat (delay - 1) @(posedge i_clk);
            compl_done <= is_rd;
            wr_done    <= !is_rd;
            @(posedge i_clk);
            compl_done <= 1'b0;
            wr_done    <= 1'b0;
        end
    end

    always @(posedge i_clk) begin
        if (req_compl) n_rd_seen <= n_rd_seen + 1;
        if (wr_en) n_wr_seen <= n_wr_seen + 1;
        if (slow_done && !rx_tready) tready_fell <= 1'b1;
        if (pcie_rx_ep_i.props_i.fail_count != 0) begin
            report_failure("an assertion in pcie_rx_ep_properties failed");
        end
    end

    initial begin
        int choice;
        i_rst_n = 1'b1;
        rx      = '0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b0;
        @(posedge i_clk);

        // Lone requests, lower half then middle start
        send_rd(1'b0);
        wait_drained();
        send_wr(1'b0);
        wait_drained();
        send_rd(1'b1);
        wait_drained();
        send_wr(1'b1);
        wait_drained();

        // Mixed traffic with valid gaps and dropped TLPs
        gaps_on = 1'b1;
        for (int i = 0; i < 24; i++) begin
            choice = $unsigned($random(stim_seed)) % 6;
            case (choice)
                0: send_rd(1'b0);
                1: send_rd(1'b1);
                2: send_wr(1'b0);
                3: send_wr(1'b1);
                4: send_discard(1'b0);
                default: send_discard(1'b1);
            endcase
        end
        wait_drained();

        // Slow done fills both FIFOs
        gaps_on   = 1'b0;
        slow_done = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_rd(i[0]);
            send_wr(1'b0);
        end
        wait_drained();
        slow_done = 1'b0;

        if (!tready_fell) begin
            report_failure("rx_tready never fell while done was slow");
        end else if (n_rd_seen != n_rd_sent || n_wr_seen != n_wr_sent) begin
            report_failure($sformatf("error at %0t ns: req_compl/wr_en counts %0d/%0d, expected %0d/%0d",
                $time, n_rd_seen, n_wr_seen, n_rd_sent, n_wr_sent));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- pcie_rx_pkg.sv
/*
 * Shared definitions for the PCIe receive endpoint.
 * Beat width, sideband bit positions, TLP header field positions,
 * the accepted format/type codes, and the packed structs for the
 * receive beat, completion requests and local writes.
 */

package pcie_rx_pkg;

    // Receive stream from the PCIe core
    localparam int DATA_WIDTH  = 128;
    localparam int TUSER_WIDTH = 22;

    // Start of frame flags in tuser
    localparam int SOF_PRESENT_BIT = 14;
    localparam int SOF_MID_BIT     = 13;

    // A header that starts mid-beat begins at dword 2
    localparam int HDR_MID_LSB = 64;
    localparam int HDR_WIDTH   = 64;
    localparam int DW_WIDTH    = 32;

    // Format/type sits in bits 30:24 of header dword 0
    localparam int FMT_TYPE_LSB   = 24;
    localparam int FMT_TYPE_WIDTH = 7;

    localparam logic [FMT_TYPE_WIDTH-1:0] MEM_RD32_FMT_TYPE = 7'b000_0000;
    localparam logic [FMT_TYPE_WIDTH-1:0] MEM_WR32_FMT_TYPE = 7'b100_0000;

    // Length in dwords, bits 9:0 of header dword 0
    localparam int LEN_WIDTH = 10;

    // One beat of the receive stream, 152 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0]  tdata;
        logic [TUSER_WIDTH-1:0] tuser;
        logic                   tlast;
        logic                   tvalid;
    } axis_rx_t;

    // Requester context and address for one completion, 81 bits
    typedef struct packed {
        // Traffic class
        logic [2:0]           tc;
        // TLP digest and poisoned flags
        logic                 td;
        logic                 ep;
        logic [1:0]           attr;
        logic [LEN_WIDTH-1:0] len;
        // Requester ID
        logic [15:0]          rid;
        logic [7:0]           tag;
        // Last and first byte enables
        logic [7:0]           be;
        logic [31:0]          addr;
    } compl_req_t;

    // One local write, 72 bits
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  be;
        logic [31:0] data;
    } mem_wr_t;

endpackage

//--- req_dispatcher.sv
/*
 * Request dispatcher.
 * Pops queued reads and writes, reads first, and issues one-cycle
 * completion and write strobes, then waits for the matching done.
 */

module req_dispatcher import pcie_rx_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  compl_req_t rd_head,
    input  logic       rd_not_empty,
    output logic       rd_pop,
    input  mem_wr_t    wr_head,
    input  logic       wr_not_empty,
    output logic       wr_pop,
    output logic       req_compl,
    output compl_req_t compl,
    input  logic       compl_done,
    output logic       wr_en,
    output mem_wr_t    wr,
    input  logic       wr_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_RD,
        S_WAIT_WR
    } state_t;

    state_t state_q;
    logic   done_seen;
    logic   can_issue;
    logic   issue_rd;
    logic   issue_wr;

    // Done only counts after the strobe cycle
    assign done_seen = (state_q == S_WAIT_RD && !req_compl && compl_done) ||
                       (state_q == S_WAIT_WR && !wr_en && wr_done);

    assign can_issue = (state_q == S_IDLE) || done_seen;
    assign issue_rd  = can_issue && rd_not_empty;
    assign issue_wr  = can_issue && !rd_not_empty && wr_not_empty;

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_q   <= S_IDLE;
            req_compl <= 1'b0;
            wr_en     <= 1'b0;
        end else begin
            req_compl <= issue_rd;
            wr_en     <= issue_wr;
            if (issue_rd) begin
                state_q <= S_WAIT_RD;
            end else if (issue_wr) begin
                state_q <= S_WAIT_WR;
            end else if (done_seen) begin
                state_q <= S_IDLE;
            end
        end
    end

    // Payload holds until the next strobe
    always_ff @(posedge i_clk) begin
        if (issue_rd) begin
            compl <= rd_head;
        end
        if (issue_wr) begin
            wr <= wr_head;
        end
    end

    // Head leaves its FIFO in the strobe cycle
    assign rd_pop = req_compl;
    assign wr_pop = wr_en;

endmodule

//--- req_fifo.sv
/*
 * Request FIFO, first word fall through, payload type set by parameter.
 * Circular buffer with read and write pointers and an occupancy count.
 * room is registered and means at least two free slots.
 */

module req_fifo #(
    parameter int  P_DEPTH   = 4,
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     room,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty
);

    localparam int AW = $clog2(P_DEPTH);

    payload_t        mem [P_DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic [AW:0]     count_next;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            room   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // Two free slots cover a push still on its way from the parser
            room  <= (count_next <= (AW + 1)'(P_DEPTH - 2));
        end
    end

    // Storage
    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

//--- tlp_rx_parser.sv
/*
 * Receive TLP parser.
 * Turns one-dword MemRd32 and MemWr32 TLPs into queued requests,
 * for headers starting in the lower half or in the middle of a beat.
 * Other TLPs are dropped up to tlast.
 */

module tlp_rx_parser import pcie_rx_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  axis_rx_t   rx,
    output logic       rx_tready,
    input  logic       rd_room,
    input  logic       wr_room,
    output logic       rd_push,
    output compl_req_t rd_req,
    output logic       wr_push,
    output mem_wr_t    wr_req
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD_DW2,
        S_WR_DW2,
        S_DISCARD
    } state_t;

    state_t     state_q;
    state_t     state_d;
    compl_req_t ctx_q;
    compl_req_t ctx_d;
    compl_req_t rd_req_d;
    mem_wr_t    wr_req_d;
    logic       rd_push_d;
    logic       wr_push_d;
    logic       mid_start;

    logic                      beat;
    logic                      sof_present;
    logic                      sof_mid;
    logic [HDR_WIDTH-1:0]      hdr_lo;
    logic [HDR_WIDTH-1:0]      hdr_mid;
    logic [FMT_TYPE_WIDTH-1:0] fmt_lo;
    logic [FMT_TYPE_WIDTH-1:0] fmt_mid;
    logic                      one_dw_lo;
    logic                      one_dw_mid;

    // Requester context from the first two header dwords
    function automatic compl_req_t header_ctx(input logic [HDR_WIDTH-1:0] hdr);
        compl_req_t c;
        c      = '0;
        c.tc   = hdr[22:20];
        c.td   = hdr[15];
        c.ep   = hdr[14];
        c.attr = hdr[13:12];
        c.len  = hdr[LEN_WIDTH-1:0];
        c.rid  = hdr[63:48];
        c.tag  = hdr[47:40];
        c.be   = hdr[39:32];
        return c;
    endfunction

    // Accept only while both queues can take another request
    assign rx_tready = rd_room && wr_room;
    assign beat      = rx.tvalid && rx_tready;

    assign sof_present = rx.tuser[SOF_PRESENT_BIT];
    assign sof_mid     = rx.tuser[SOF_MID_BIT];

    assign hdr_lo     = rx.tdata[HDR_WIDTH-1:0];
    assign hdr_mid    = rx.tdata[HDR_MID_LSB +: HDR_WIDTH];
    assign fmt_lo     = hdr_lo[FMT_TYPE_LSB +: FMT_TYPE_WIDTH];
    assign fmt_mid    = hdr_mid[FMT_TYPE_LSB +: FMT_TYPE_WIDTH];
    assign one_dw_lo  = (hdr_lo[LEN_WIDTH-1:0] == LEN_WIDTH'(1));
    assign one_dw_mid = (hdr_mid[LEN_WIDTH-1:0] == LEN_WIDTH'(1));

    always_comb begin
        state_d   = state_q;
        ctx_d     = ctx_q;
        rd_push_d = 1'b0;
        wr_push_d = 1'b0;
        rd_req_d  = rd_req;
        wr_req_d  = wr_req;
        mid_start = 1'b0;
        if (beat) begin
            case (state_q)
                S_IDLE: begin
                    if (sof_present && !sof_mid) begin
                        // Header, address and data all in this beat
                        if (one_dw_lo && fmt_lo == MEM_RD32_FMT_TYPE) begin
                            rd_push_d     = 1'b1;
                            rd_req_d      = header_ctx(hdr_lo);
                            rd_req_d.addr = rx.tdata[95:64];
                        end else if (one_dw_lo && fmt_lo == MEM_WR32_FMT_TYPE) begin
                            wr_push_d     = 1'b1;
                            wr_req_d.addr = rx.tdata[95:64];
                            wr_req_d.be   = hdr_lo[39:32];
                            wr_req_d.data = rx.tdata[127:96];
                        end else if (!rx.tlast) begin
                            state_d = S_DISCARD;
                        end
                    end else if (sof_present) begin
                        mid_start = 1'b1;
                    end
                end
                S_RD_DW2: begin
                    rd_push_d     = 1'b1;
                    rd_req_d      = ctx_q;
                    rd_req_d.addr = rx.tdata[DW_WIDTH-1:0];
                    state_d       = S_IDLE;
                    mid_start     = sof_present && sof_mid;
                end
                S_WR_DW2: begin
                    wr_push_d     = 1'b1;
                    wr_req_d.addr = rx.tdata[DW_WIDTH-1:0];
                    wr_req_d.be   = ctx_q.be;
                    wr_req_d.data = rx.tdata[2*DW_WIDTH-1:DW_WIDTH];
                    state_d       = S_IDLE;
                    mid_start     = sof_present && sof_mid;
                end
                S_DISCARD: begin
                    if (rx.tlast) begin
                        state_d   = S_IDLE;
                        mid_start = sof_present && sof_mid;
                    end
                end
                default: state_d = S_IDLE;
            endcase

            // A new header may start in the upper half of any consumed beat
            if (mid_start) begin
                ctx_d = header_ctx(hdr_mid);
                if (one_dw_mid && fmt_mid == MEM_RD32_FMT_TYPE) begin
                    state_d = S_RD_DW2;
                end else if (one_dw_mid && fmt_mid == MEM_WR32_FMT_TYPE) begin
                    state_d = S_WR_DW2;
                end else begin
                    state_d = S_DISCARD;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_q <= S_IDLE;
            rd_push <= 1'b0;
            wr_push <= 1'b0;
        end else begin
            state_q <= state_d;
            rd_push <= rd_push_d;
            wr_push <= wr_push_d;
        end
    end

    // Header context and request payloads
    always_ff @(posedge i_clk) begin
        ctx_q  <= ctx_d;
        rd_req <= rd_req_d;
        wr_req <= wr_req_d;
    end

endmodule
